/* design/accum.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_accum_cfg.svh"

module accum (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_accum_pkg::lane_t a,
    input  conv_accum_pkg::lane_t b,
    input  logic                  operation_nd,
    output conv_accum_pkg::lane_t result,
    output logic                  rdy
);
    import conv_accum_pkg::*;

    localparam lane_t lane_max = {1'b0, {(`LANE_W-1){1'b1}}};
    localparam lane_t lane_min = {1'b1, {(`LANE_W-1){1'b0}}};

    logic signed [`LANE_W:0] sum_q;     // One guard bit catches the overflow.
    logic                    sum_vld;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum_vld <= 1'b0;
            rdy     <= 1'b0;
        end else begin
            sum_vld <= operation_nd;
            rdy     <= sum_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (operation_nd) begin
            sum_q <= {a[`LANE_W-1], a} + {b[`LANE_W-1], b};
        end
        if (sum_vld) begin
            // Guard and sign bits differ only when the sum left the lane range.
            if (sum_q[`LANE_W] != sum_q[`LANE_W-1]) begin
                result <= sum_q[`LANE_W] ? lane_min : lane_max;
            end else begin
                result <= sum_q[`LANE_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* design/conv_accum_cfg.svh */
`ifndef CONV_ACCUM_CFG_SVH
`define CONV_ACCUM_CFG_SVH

// Lanes carried by one burst from the convolution engine.
`define BURST_LEN 8

// Width of one signed lane, of the bias and of every sum.
`define LANE_W 16

// Entries in the per-index sum memory. This is the largest output side supported.
`define MAX_O_SIDE 128

// Bursts the input FIFO can hold.
`define FIFO_DEPTH 4

// Cycles from operation_nd to rdy in the saturating adder.
`define ACC_LAT 2

`endif

/* design/conv_accum_pkg.sv */
`default_nettype none

`include "conv_accum_cfg.svh"

package conv_accum_pkg;

    // One signed lane. The bias, the running sum and the result use it too.
    typedef logic signed [`LANE_W-1:0] lane_t;

    // All lanes of a burst, lane 0 in the low bits.
    typedef logic [`BURST_LEN*`LANE_W-1:0] burst_data_t;

    // Output position that selects a sum memory entry.
    typedef logic [$clog2(`MAX_O_SIDE)-1:0] o_index_t;

    // Input-channel counter. Zero marks the first channel of an output.
    typedef logic [15:0] ch_count_t;

    typedef struct packed {
        burst_data_t data;
        o_index_t    index;
        ch_count_t   ch_count;
        lane_t       bias;
    } psum_burst_t;

    typedef enum logic {
        fsum_idle,
        fsum_busy
    } fsum_state_t;

endpackage

`default_nettype wire

/* design/conv_accum_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accum_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  conv_accum_pkg::psum_burst_t wr_burst,
    output logic                        full,
    output conv_accum_pkg::lane_t       result,
    output logic                        result_valid
);
    import conv_accum_pkg::*;

    logic        fifo_empty;
    logic        fifo_reads_en;
    psum_burst_t fifo_burst;
    logic        fifo_valid;

    // Bursts wait here until the accumulator is idle.
    psum_fifo psum_fifo_inst (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .wr_burst (wr_burst),
        .full     (full),
        .empty    (fifo_empty),
        .reads_en (fifo_reads_en),
        .rd_burst (fifo_burst),
        .valid    (fifo_valid)
    );

    fsum fsum_inst (
        .clk          (clk),
        .rst          (rst),
        .empty        (fifo_empty),
        .reads_en     (fifo_reads_en),
        .burst        (fifo_burst),
        .valid        (fifo_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

/* design/fsum.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_accum_cfg.svh"

module fsum (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        empty,
    output logic                        reads_en,
    input  conv_accum_pkg::psum_burst_t burst,
    input  logic                        valid,
    output conv_accum_pkg::lane_t       result,
    output logic                        result_valid
);
    import conv_accum_pkg::*;

    localparam int idx_w = $clog2(`BURST_LEN);
    localparam int cnt_w = idx_w + 1;
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`BURST_LEN);

    fsum_state_t      state;
    lane_t            sum_mem [`MAX_O_SIDE];
    burst_data_t      data_q;
    o_index_t         index_q;
    logic [cnt_w-1:0] lane_cnt;     // Next lane to send to the adder.
    lane_t            acc_a;
    lane_t            acc_b;
    lane_t            acc_result;
    logic             acc_nd;
    logic             acc_rdy;
    logic             start_add;
    logic             next_add;
    logic             finish;

    function automatic lane_t lane_of(burst_data_t d, logic [idx_w-1:0] i);
        return d[i*`LANE_W +: `LANE_W];
    endfunction

    accum accum_inst (
        .clk          (clk),
        .rst          (rst),
        .a            (acc_a),
        .b            (acc_b),
        .operation_nd (acc_nd),
        .result       (acc_result),
        .rdy          (acc_rdy)
    );

    assign start_add = (state == fsum_busy) && valid;
    assign next_add  = acc_rdy && (lane_cnt != last_cnt);
    assign finish    = acc_rdy && (lane_cnt == last_cnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= fsum_idle;
            reads_en     <= 1'b0;
            acc_nd       <= 1'b0;
            lane_cnt     <= '0;
            result_valid <= 1'b0;
        end else begin
            reads_en     <= 1'b0;
            acc_nd       <= start_add || next_add;
            result_valid <= finish;
            case (state)
                fsum_idle: begin
                    if (!empty) begin
                        reads_en <= 1'b1;   // A single pop per burst.
                        state    <= fsum_busy;
                    end
                end
                fsum_busy: begin
                    if (finish) begin
                        state <= fsum_idle;
                    end
                end
                default: state <= fsum_idle;
            endcase
            if (start_add) begin
                lane_cnt <= cnt_w'(1);
            end else if (next_add) begin
                lane_cnt <= lane_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_add) begin
            data_q  <= burst.data;
            index_q <= burst.index;
            // The first channel starts from the bias, later ones from the stored sum.
            if (burst.ch_count == '0) begin
                acc_a <= burst.bias;
            end else begin
                acc_a <= sum_mem[burst.index];
            end
            acc_b <= lane_of(burst.data, '0);
        end else if (next_add) begin
            acc_a <= acc_result;
            acc_b <= lane_of(data_q, lane_cnt[idx_w-1:0]);
        end
        if (finish) begin
            sum_mem[index_q] <= acc_result;
            result           <= acc_result;
        end
    end

    rdy_only_when_busy: assert property (
        @(posedge clk) disable iff (rst) acc_rdy |-> (state == fsum_busy)
    ) else $error("fsum: adder result arrived while idle");

    pop_returns_burst: assert property (
        @(posedge clk) disable iff (rst) reads_en |=> valid
    ) else $error("fsum: no burst came back one cycle after the FIFO read");

endmodule

`default_nettype wire

/* design/psum_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_accum_cfg.svh"

module psum_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  conv_accum_pkg::psum_burst_t wr_burst,
    output logic                        full,
    output logic                        empty,
    input  logic                        reads_en,
    output conv_accum_pkg::psum_burst_t rd_burst,
    output logic                        valid
);
    import conv_accum_pkg::*;

    localparam int ptr_w = $clog2(`FIFO_DEPTH);
    localparam int cnt_w = $clog2(`FIFO_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`FIFO_DEPTH - 1);
    localparam logic [cnt_w-1:0] depth_cnt = cnt_w'(`FIFO_DEPTH);

    psum_burst_t      mem [`FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == depth_cnt);
    assign empty   = (count == '0);
    assign do_push = push && !full;     // A push into a full FIFO is dropped.
    assign do_pop  = reads_en && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_pop;
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Push and pop together keep the level.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_burst;
        end
        if (do_pop) begin
            rd_burst <= mem[rd_ptr];    // Held until the next pop.
        end
    end

    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("psum_fifo: producer pushed while the FIFO was full");

    no_read_when_empty: assert property (
        @(posedge clk) disable iff (rst) reads_en |-> !empty
    ) else $error("psum_fifo: read requested while the FIFO was empty");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the accumulation stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module conv_accum_tb \
    --Mdir obj_dir \
    -o Vconv_accum_tb \
    -f sim.f

./obj_dir/Vconv_accum_tb 2>&1 | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* sim.f */
+incdir+design
design/conv_accum_pkg.sv
design/psum_fifo.sv
design/accum.sv
design/fsum.sv
design/conv_accum_top.sv
test/conv_accum_tb.sv

/* test/conv_accum_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_accum_cfg.svh"

module conv_accum_tb;
    import conv_accum_pkg::*;

    localparam int lane_hi = (1 << (`LANE_W - 1)) - 1;
    localparam int lane_lo = -(1 << (`LANE_W - 1));
    localparam int total_bursts = 1 + 4 + 9 + 4 + (`FIFO_DEPTH + 2) + 50;
    localparam int cycle_limit = total_bursts * 40 + 200;

    logic        clk;
    logic        rst;
    logic        push;
    psum_burst_t wr_burst;
    logic        full;
    lane_t       result;
    logic        result_valid;

    psum_burst_t               expect_q [$];
    lane_t [`MAX_O_SIDE-1:0]   shadow_sums;   // Model copy of the DUT sum memory.
    psum_burst_t               popped;
    lane_t                     expected;
    int                        errors;
    int                        errors_at_start;
    int                        tests_run;
    int                        pushed;
    int                        results_seen;
    int                        cycle_count;
    logic                      full_seen;

    conv_accum_top conv_accum_top_inst (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .wr_burst     (wr_burst),
        .full         (full),
        .result       (result),
        .result_valid (result_valid)
    );

    always #50 clk = ~clk;

    // Each lane is added to the running sum and clamped before the next one.
    function automatic lane_t model_sum(input psum_burst_t b,
                                        inout lane_t [`MAX_O_SIDE-1:0] shadow);
        int    acc;
        lane_t lane;
        if (b.ch_count == '0) begin
            acc = int'(b.bias);
        end else begin
            acc = int'(shadow[b.index]);
        end
        for (int i = 0; i < `BURST_LEN; i++) begin
            lane = b.data[i*`LANE_W +: `LANE_W];
            acc  = acc + int'(lane);
            if (acc > lane_hi) begin
                acc = lane_hi;
            end else if (acc < lane_lo) begin
                acc = lane_lo;
            end
        end
        shadow[b.index] = lane_t'(acc);
        return lane_t'(acc);
    endfunction

    function automatic burst_data_t put_lane(input burst_data_t d, input int i, input lane_t v);
        d[i*`LANE_W +: `LANE_W] = v;
        return d;
    endfunction

    // Uniform over -span to span-1.
    function automatic lane_t rand_lane(input int span);
        return lane_t'(int'($urandom_range(2 * span - 1, 0)) - span);
    endfunction

    function automatic psum_burst_t make_burst(input int index, input int ch,
                                               input lane_t bias, input int span);
        psum_burst_t b;
        b.index    = o_index_t'(index);
        b.ch_count = ch_count_t'(ch);
        b.bias     = bias;
        b.data     = '0;
        for (int i = 0; i < `BURST_LEN; i++) begin
            b.data = put_lane(b.data, i, rand_lane(span));
        end
        return b;
    endfunction

    task automatic check_value(input string name, input lane_t exp_val, input lane_t act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp_val, act_val);
            errors++;
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same phase.
    task automatic push_burst(input psum_burst_t b);
        while (full) begin
            @(posedge clk);
            #1;
        end
        push     = 1'b1;
        wr_burst = b;
        expect_q.push_back(b);
        pushed++;
        @(posedge clk);
        #1;
        push = 1'b0;
    endtask

    task automatic wait_results();
        while (results_seen != pushed) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == errors_at_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        tests_run++;
        errors_at_start = errors;
    endtask

    // Outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!rst) begin
            if (full) begin
                full_seen = 1'b1;
            end
            if (result_valid) begin
                if (expect_q.size() == 0) begin
                    $display("A result appeared with no burst outstanding.");
                    errors++;
                end else begin
                    popped   = expect_q.pop_front();
                    expected = model_sum(popped, shadow_sums);
                    check_value("result", expected, result);
                    results_seen++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, results still outstanding.", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        psum_burst_t b;
        int          idx;
        int          ch;
        bit          started [8];
        clk             = 1'b0;
        rst             = 1'b1;
        push            = 1'b0;
        wr_burst        = '0;
        shadow_sums     = '0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        pushed          = 0;
        results_seen    = 0;
        cycle_count     = 0;
        full_seen       = 1'b0;
        started         = '{default: 1'b0};
        idx             = $urandom(26052);
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value("result_valid", lane_t'(0), lane_t'(result_valid));
        check_value("full", lane_t'(0), lane_t'(full));
        repeat (20) @(posedge clk);
        #1;
        report_test("Test 1 quiet after reset");

        push_burst(make_burst(3, 0, rand_lane(4096), 32768));
        wait_results();
        report_test("Test 2 single burst from bias");

        b = make_burst(5, 0, rand_lane(1024), 1024);
        push_burst(b);
        for (int c = 1; c < 4; c++) begin
            push_burst(make_burst(5, c, lane_t'(0), 1024));
        end
        wait_results();
        report_test("Test 3 one index over four channels");

        push_burst(make_burst(10, 0, rand_lane(2048), 2048));
        push_burst(make_burst(20, 0, rand_lane(2048), 2048));
        push_burst(make_burst(30, 0, rand_lane(2048), 2048));
        push_burst(make_burst(10, 1, lane_t'(0), 2048));
        push_burst(make_burst(20, 1, lane_t'(0), 2048));
        push_burst(make_burst(30, 1, lane_t'(0), 2048));
        push_burst(make_burst(20, 0, rand_lane(2048), 2048));   // Restart drops the old sum.
        push_burst(make_burst(20, 1, lane_t'(0), 2048));
        push_burst(make_burst(10, 2, lane_t'(0), 2048));
        wait_results();
        report_test("Test 4 interleaved indices");

        b = make_burst(40, 0, lane_t'(32000), 1);
        b.data = put_lane(b.data, 0, lane_t'(30000));
        b.data = put_lane(b.data, 1, lane_t'(30000));
        b.data = put_lane(b.data, 2, lane_t'(-20000));
        b.data = put_lane(b.data, 3, lane_t'(-32768));
        b.data = put_lane(b.data, 4, lane_t'(-32768));
        b.data = put_lane(b.data, 5, lane_t'(-32768));
        b.data = put_lane(b.data, 6, lane_t'(1000));
        b.data = put_lane(b.data, 7, lane_t'(5));
        push_burst(b);
        b = make_burst(40, 1, lane_t'(0), 1);
        for (int i = 0; i < `BURST_LEN; i++) begin
            b.data = put_lane(b.data, i, lane_t'(-30000));
        end
        push_burst(b);
        b = make_burst(41, 0, lane_t'(-32768), 1);
        for (int i = 0; i < `BURST_LEN; i++) begin
            b.data = put_lane(b.data, i, lane_t'(-1000));
        end
        b.data = put_lane(b.data, `BURST_LEN - 1, lane_t'(32767));
        push_burst(b);
        b = make_burst(41, 1, lane_t'(0), 1);
        for (int i = 0; i < `BURST_LEN; i++) begin
            b.data = put_lane(b.data, i, lane_t'(32767));
        end
        push_burst(b);
        wait_results();
        report_test("Test 5 saturation at both limits");

        full_seen = 1'b0;
        for (int n = 0; n < `FIFO_DEPTH + 2; n++) begin
            push_burst(make_burst(60 + n, 0, rand_lane(4096), 4096));
        end
        check_value("full_seen", lane_t'(1), lane_t'(full_seen));
        for (int n = 0; n < 50; n++) begin
            idx = int'($urandom_range(7, 0));
            if (started[idx]) begin
                ch = int'($urandom_range(3, 0));
            end else begin
                ch = 0;     // An index needs a first channel before it can build.
            end
            started[idx] = 1'b1;
            push_burst(make_burst(idx, ch, rand_lane(2048), 8192));
        end
        wait_results();
        report_test("Test 6 full FIFO and random bursts");

        $display("Tests run: %0d  Results checked: %0d  Errors: %0d",
                 tests_run, results_seen, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
